/* common/fetch_pkg.sv */
`default_nettype none

package fetch_pkg;

    // first fetch after reset, in uncached kseg1
    localparam logic [31:0] reset_pc = 32'hbfc0_0000;

    // general exception entry point
    localparam logic [31:0] exc_vector = 32'hbfc0_0380;

    // clears the top three bits so kseg0 and kseg1 map onto physical memory
    localparam logic [31:0] kseg_mask = 32'h1fff_ffff;

    // major opcodes of the transfers decoded in the front end
    localparam logic [5:0] op_j   = 6'h02;
    localparam logic [5:0] op_jal = 6'h03;
    localparam logic [5:0] op_beq = 6'h04;

    // accepted requests that may wait for data at the same time
    localparam int max_outstanding = 2;

    // widths of the pc FIFO pointer and of its occupancy counters
    localparam int fifo_ptr_w = $clog2(max_outstanding);
    localparam int fifo_cnt_w = $clog2(max_outstanding + 1);

    // read request toward the instruction memory, addr is physical
    typedef struct packed {
        logic        req;
        logic [31:0] addr;
    } mem_req_t;

    // address accept, data return and read data from the instruction memory
    typedef struct packed {
        logic        addr_ok;
        logic        data_ok;
        logic [31:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] inst;
    } fetch_pkt_t;

    // one-cycle pulse from the exception logic
    typedef struct packed {
        logic        exception;
        logic        eret;
        logic [31:0] epc;
    } redirect_t;

    // next-pc information from decode back to the pc selection
    typedef struct packed {
        logic        taken;
        logic [31:0] target;
        logic        fire;
    } flow_t;

endpackage

`default_nettype wire

/* fetch/if_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module if_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  issue,
    input  logic [31:0]           issued_pc,
    input  fetch_pkg::mem_rsp_t   mem_rsp,
    input  fetch_pkg::redirect_t  redirect,
    input  logic                  take,
    output logic                  slot_free,
    output fetch_pkg::fetch_pkt_t pkt
);

    // each entry holds the pc of a request and later its returned word
    logic [31:0] pc_q   [fetch_pkg::max_outstanding];
    logic [31:0] inst_q [fetch_pkg::max_outstanding];

    logic [fetch_pkg::fifo_ptr_w-1:0] rd_ptr;
    logic [fetch_pkg::fifo_ptr_w-1:0] ret_idx;
    logic [fetch_pkg::fifo_ptr_w-1:0] wr_idx;

    // entries waiting for data, entries holding data, returns to drop
    logic [fetch_pkg::fifo_cnt_w-1:0] outstanding;
    logic [fetch_pkg::fifo_cnt_w-1:0] ready;
    logic [fetch_pkg::fifo_cnt_w-1:0] discard;

    logic pulse;
    logic keep_ok;
    logic drop_ok;

    assign pulse   = redirect.exception | redirect.eret;
    assign drop_ok = mem_rsp.data_ok & (discard != '0);
    assign keep_ok = mem_rsp.data_ok & (discard == '0);

    // data returns in order, right behind the entries that already hold data
    assign ret_idx = rd_ptr + fetch_pkg::fifo_ptr_w'(ready);
    assign wr_idx  = rd_ptr + fetch_pkg::fifo_ptr_w'(ready + outstanding);

    // stale returns still occupy the memory, so they count too
    assign slot_free = (int'(outstanding) + int'(ready) + int'(discard))
                       < fetch_pkg::max_outstanding;

    assign pkt.valid = (ready != '0);
    assign pkt.pc    = pc_q[rd_ptr];
    assign pkt.inst  = inst_q[rd_ptr];

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr      <= '0;
            outstanding <= '0;
            ready       <= '0;
            discard     <= '0;
        end else if (pulse) begin
            outstanding <= '0;
            ready       <= '0;
            // all requests still in the memory become stale
            discard     <= discard + outstanding
                           - fetch_pkg::fifo_cnt_w'(mem_rsp.data_ok);
        end else begin
            if (take) begin
                rd_ptr <= rd_ptr + fetch_pkg::fifo_ptr_w'(1);
            end
            outstanding <= outstanding + fetch_pkg::fifo_cnt_w'(issue)
                           - fetch_pkg::fifo_cnt_w'(keep_ok);
            ready       <= ready + fetch_pkg::fifo_cnt_w'(keep_ok)
                           - fetch_pkg::fifo_cnt_w'(take);
            discard     <= discard - fetch_pkg::fifo_cnt_w'(drop_ok);
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            pc_q[wr_idx] <= issued_pc;
        end
        if (keep_ok) begin
            inst_q[ret_idx] <= mem_rsp.rdata;
        end
    end

    // every data_ok belongs to some request the memory accepted earlier
    a_rsp_expected: assert property (
        @(posedge clk) disable iff (reset)
        mem_rsp.data_ok |-> (outstanding != '0) || (discard != '0)
    );

    // live entries and stale returns together never exceed the FIFO depth
    a_no_overflow: assert property (
        @(posedge clk) disable iff (reset)
        (int'(outstanding) + int'(ready) + int'(discard)) <= fetch_pkg::max_outstanding
    );

endmodule

`default_nettype wire

/* fetch/pre_if.sv */
`timescale 1ns/1ps
`default_nettype none

module pre_if (
    input  logic                 clk,
    input  logic                 reset,
    input  fetch_pkg::redirect_t redirect,
    input  fetch_pkg::flow_t     flow,
    input  logic                 slot_free,
    output fetch_pkg::mem_req_t  mem_req,
    input  logic                 addr_ok,
    output logic [31:0]          issued_pc,
    output logic                 issue
);

    // virtual address of the next request
    logic [31:0] pc;

    // target saved while its delay slot still has to be requested
    logic [31:0] target_q;
    logic        use_target;

    // low for the first cycle after reset
    logic        started;

    // instructions requested but not yet out of decode
    logic [1:0]  in_flight;

    logic        pulse;
    logic        taken_fire;
    logic        slot_missed;
    logic        room;

    assign pulse      = redirect.exception | redirect.eret;
    assign taken_fire = flow.fire & flow.taken;

    // at most the instruction in decode and one more are in flight, so a
    // transfer in decode has never been fetched past its delay slot
    assign room = (in_flight < 2'd2);

    // transfer leaves with only itself in flight and nothing accepted now
    assign slot_missed = taken_fire & (in_flight == 2'd1) & ~issue;

    assign mem_req.req  = started & slot_free & room & ~pulse;
    // fixed segment mapping
    assign mem_req.addr = pc & fetch_pkg::kseg_mask;

    assign issue     = mem_req.req & addr_ok;
    assign issued_pc = pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            started <= 1'b0;
        end else begin
            started <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= 2'd0;
        end else if (pulse) begin
            // everything in flight is thrown away downstream
            in_flight <= 2'd0;
        end else begin
            in_flight <= in_flight + 2'(issue) - 2'(flow.fire);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            pc         <= fetch_pkg::reset_pc;
            use_target <= 1'b0;
        end else if (pulse) begin
            use_target <= 1'b0;
            if (redirect.exception) begin
                pc <= fetch_pkg::exc_vector;
            end else begin
                pc <= redirect.epc;
            end
        end else if (slot_missed) begin
            // pc already points at the delay slot, keep it and jump after
            use_target <= 1'b1;
        end else if (taken_fire) begin
            // delay slot requested already or accepted in this cycle
            pc <= flow.target;
        end else if (issue) begin
            if (use_target) begin
                pc         <= target_q;
                use_target <= 1'b0;
            end else begin
                pc <= pc + 32'd4;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (slot_missed) begin
            target_q <= flow.target;
        end
    end

    // a pending request keeps its address until the memory takes it
    a_req_steady: assert property (
        @(posedge clk) disable iff (reset)
        (mem_req.req && !addr_ok) ##1 !pulse |-> mem_req.req && $stable(mem_req.addr)
    );

    // a saved target goes out before any later word can leave decode
    a_target_first: assert property (
        @(posedge clk) disable iff (reset)
        use_target |-> !flow.fire
    );

endmodule

`default_nettype wire

/* fetch_unit.f */
common/fetch_pkg.sv
fetch/pre_if.sv
fetch/if_stage.sv
hw/branch_decode.sv
hw/fetch_top.sv
tests/inst_mem_model.sv
tests/tb_fetch.sv

/* hw/branch_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module branch_decode (
    input  logic                  clk,
    input  logic                  reset,
    input  fetch_pkg::fetch_pkt_t in_pkt,
    output logic                  take,
    input  fetch_pkg::redirect_t  redirect,
    output fetch_pkg::flow_t      flow,
    output fetch_pkg::fetch_pkt_t out_pkt,
    input  logic                  out_ready
);

    logic        valid_q;
    logic [31:0] pc_q;
    logic [31:0] inst_q;

    logic        pulse;
    logic        load;
    logic [5:0]  opcode;
    logic        is_jump;
    logic        is_b;
    logic [31:0] pc_plus4;
    logic [31:0] j_target;
    logic [31:0] b_target;

    assign pulse = redirect.exception | redirect.eret;

    // register is free when empty or when its word leaves now
    assign load = ~valid_q | out_ready;
    assign take = load & in_pkt.valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (pulse) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= in_pkt.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            pc_q   <= in_pkt.pc;
            inst_q <= in_pkt.inst;
        end
    end

    assign opcode  = inst_q[31:26];
    assign is_jump = (opcode == fetch_pkg::op_j) || (opcode == fetch_pkg::op_jal);
    // b is beq with rs and rt both zero, so it is always taken
    assign is_b    = (opcode == fetch_pkg::op_beq)
                     && (inst_q[25:21] == 5'd0) && (inst_q[20:16] == 5'd0);

    assign pc_plus4 = pc_q + 32'd4;
    // j and jal stay inside the 256 MB region of the delay slot
    assign j_target = {pc_plus4[31:28], inst_q[25:0], 2'b00};
    assign b_target = pc_plus4 + {{14{inst_q[15]}}, inst_q[15:0], 2'b00};

    assign flow.taken  = valid_q & (is_jump | is_b);
    assign flow.target = is_jump ? j_target : b_target;
    assign flow.fire   = valid_q & out_ready;

    assign out_pkt.valid = valid_q;
    assign out_pkt.pc    = pc_q;
    assign out_pkt.inst  = inst_q;

    // a stalled word stays put unless a redirect flushes it
    a_out_hold: assert property (
        @(posedge clk) disable iff (reset)
        (out_pkt.valid && !out_ready && !pulse) |=> out_pkt.valid && $stable(out_pkt)
    );

endmodule

`default_nettype wire

/* hw/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                  clk,
    input  logic                  reset,
    output fetch_pkg::mem_req_t   mem_req,
    input  fetch_pkg::mem_rsp_t   mem_rsp,
    input  fetch_pkg::redirect_t  redirect,
    output fetch_pkg::fetch_pkt_t out_pkt,
    input  logic                  out_ready
);

    // decode back to pc selection
    fetch_pkg::flow_t      flow;

    // request tracking between pc selection and the fetch buffer
    logic                  slot_free;
    logic                  issue;
    logic [31:0]           issued_pc;

    // fetched word and its handoff into decode
    fetch_pkg::fetch_pkt_t if_pkt;
    logic                  take;

    pre_if u_pre_if (
        .clk       (clk),
        .reset     (reset),
        .redirect  (redirect),
        .flow      (flow),
        .slot_free (slot_free),
        .mem_req   (mem_req),
        .addr_ok   (mem_rsp.addr_ok),
        .issued_pc (issued_pc),
        .issue     (issue)
    );

    if_stage u_if_stage (
        .clk       (clk),
        .reset     (reset),
        .issue     (issue),
        .issued_pc (issued_pc),
        .mem_rsp   (mem_rsp),
        .redirect  (redirect),
        .take      (take),
        .slot_free (slot_free),
        .pkt       (if_pkt)
    );

    branch_decode u_branch_decode (
        .clk       (clk),
        .reset     (reset),
        .in_pkt    (if_pkt),
        .take      (take),
        .redirect  (redirect),
        .flow      (flow),
        .out_pkt   (out_pkt),
        .out_ready (out_ready)
    );

endmodule

`default_nettype wire

/* tests/inst_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_mem_model #(
    parameter logic [31:0] base  = 32'h1fc0_0000,
    parameter int          depth = 4096
) (
    input  logic                clk,
    input  logic                reset,
    input  fetch_pkg::mem_req_t mem_req,
    output fetch_pkg::mem_rsp_t mem_rsp
);

    // program words from base onward, physical word addresses
    logic [31:0] prog [depth];

    // accepted reads waiting for data, oldest first
    logic [31:0] pend_addr [$];
    int          pend_due [$];

    logic [31:0] rng = 32'd13;
    int          cyc = 0;
    int          last_due = 0;
    int          accept_wait = 0;
    logic        data_ok_q = 1'b0;
    logic [31:0] rdata_q = 32'h0;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // background word, opcode zero so it never decodes as a transfer
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        logic [31:0] h;
        h = addr ^ (addr >> 15);
        h = h * 32'h2c1b_3c6d;
        h = h ^ (h >> 12);
        return {6'h00, h[25:0]};
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] addr);
        logic [31:0] off;
        off = addr - base;
        if (off[31:2] < depth) begin
            return prog[off[31:2]];
        end
        return fill_word(addr);
    endfunction

    initial begin
        for (int i = 0; i < depth; i++) begin
            prog[i] = fill_word(base + 32'(i) * 32'd4);
        end
    end

    assign mem_rsp.addr_ok = mem_req.req && (accept_wait == 0);
    assign mem_rsp.data_ok = data_ok_q;
    assign mem_rsp.rdata   = rdata_q;

    always @(posedge clk) begin
        int          due;
        logic [31:0] addr;
        if (reset) begin
            pend_addr.delete();
            pend_due.delete();
            cyc = 0;
            last_due = 0;
            accept_wait <= 0;
            data_ok_q <= 1'b0;
        end else begin
            if (mem_req.req && mem_rsp.addr_ok) begin
                rng = xorshift32(rng);
                // latency of 1 to 4 cycles, but never ahead of an older read
                due = cyc + 1 + int'(rng % 4);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                pend_addr.push_back(mem_req.addr);
                pend_due.push_back(due);
                rng = xorshift32(rng);
                accept_wait <= int'(rng % 3);
            end else if (mem_req.req && accept_wait > 0) begin
                accept_wait <= accept_wait - 1;
            end
            cyc = cyc + 1;
            if (pend_due.size() > 0 && pend_due[0] == cyc) begin
                addr = pend_addr.pop_front();
                due = pend_due.pop_front();
                data_ok_q <= 1'b1;
                rdata_q <= read_word(addr);
            end else begin
                data_ok_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* tests/tb_fetch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch;

    localparam logic [31:0] mem_base  = 32'h1fc0_0000;
    localparam int          mem_depth = 4096;
    // about 400 words over all tests, none needs more than 10 cycles
    localparam int          timeout_cycles = 400 * 10;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  out_ready;
    fetch_pkg::redirect_t  redirect;
    fetch_pkg::mem_req_t   mem_req;
    fetch_pkg::mem_rsp_t   mem_rsp;
    fetch_pkg::fetch_pkt_t out_pkt;

    logic [31:0] got_pc [$];
    logic [31:0] got_inst [$];
    logic [31:0] exp_pc [$];
    logic [31:0] exp_inst [$];
    logic [31:0] rng = 32'd13;
    int          cycles = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          errors = 0;
    int          test_errors = 0;

    fetch_top uut (
        .clk       (clk),
        .reset     (reset),
        .mem_req   (mem_req),
        .mem_rsp   (mem_rsp),
        .redirect  (redirect),
        .out_pkt   (out_pkt),
        .out_ready (out_ready)
    );

    inst_mem_model #(.base(mem_base), .depth(mem_depth)) mem_model (
        .clk     (clk),
        .reset   (reset),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    always #50 clk = ~clk;

    // every word that leaves through the output handshake
    always @(posedge clk) begin
        if (!reset && out_pkt.valid && out_ready) begin
            got_pc.push_back(out_pkt.pc);
            got_inst.push_back(out_pkt.inst);
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > timeout_cycles) begin
            $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // kseg0 and kseg1 both map by dropping the top three bits
    function automatic logic [31:0] word_index(input logic [31:0] vaddr);
        return ((vaddr & 32'h1fff_ffff) - mem_base) >> 2;
    endfunction

    function automatic logic [31:0] word_at(input logic [31:0] vaddr);
        if (word_index(vaddr) >= mem_depth) begin
            $display("reference model left the program window at %h", vaddr);
            test_errors++;
            return 32'h0;
        end
        return mem_model.prog[word_index(vaddr)];
    endfunction

    function automatic logic [31:0] jump_word(input logic [5:0] op, input logic [31:0] target);
        return {op, target[27:2]};
    endfunction

    function automatic logic [31:0] b_word(input logic [31:0] pc, input logic [31:0] target);
        logic [31:0] diff;
        diff = target - pc - 32'd4;
        return {fetch_pkg::op_beq, 10'd0, diff[17:2]};
    endfunction

    // walks the program, delay slot first and then the target
    task automatic build_expected(input logic [31:0] start, input int count);
        logic [31:0] pc;
        logic [31:0] inst;
        logic [31:0] saved;
        logic        pending;
        exp_pc.delete();
        exp_inst.delete();
        pc = start;
        saved = 32'h0;
        pending = 1'b0;
        for (int i = 0; i < count; i++) begin
            inst = word_at(pc);
            exp_pc.push_back(pc);
            exp_inst.push_back(inst);
            if (pending) begin
                pc = saved;
                pending = 1'b0;
            end else begin
                if (inst[31:26] == fetch_pkg::op_j || inst[31:26] == fetch_pkg::op_jal) begin
                    saved = {pc[31:28] + 4'(pc[27:2] == 26'h3ffffff), inst[25:0], 2'b00};
                    pending = 1'b1;
                end else if (inst[31:26] == fetch_pkg::op_beq && inst[25:16] == 10'd0) begin
                    saved = pc + 32'd4 + 32'($signed(inst[15:0])) * 32'd4;
                    pending = 1'b1;
                end
                pc = pc + 32'd4;
            end
        end
    endtask

    task automatic compare_stream(input string name, input int count);
        for (int i = 0; i < count; i++) begin
            if (got_pc[i] !== exp_pc[i] || got_inst[i] !== exp_inst[i]) begin
                $display("mismatch %s word %0d expected %h:%h actual %h:%h", name, i,
                         exp_pc[i], exp_inst[i], got_pc[i], got_inst[i]);
                test_errors++;
            end
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        errors += test_errors;
        if (test_errors == 0) begin
            $display("test %s passed", name);
        end else begin
            tests_failed++;
            $display("test %s failed with %0d errors", name, test_errors);
        end
    endtask

    // called on a falling edge, output stalled so nothing leaves in the flush cycle
    task automatic pulse_redirect(input logic exc, input logic [31:0] epc);
        got_pc.delete();
        got_inst.delete();
        out_ready = 1'b0;
        redirect.exception = exc;
        redirect.eret = ~exc;
        redirect.epc = epc;
        @(negedge clk);
        redirect = '0;
    endtask

    task automatic deliver(input int count, input logic random_ready);
        while (got_pc.size() < count) begin
            rng = xorshift32(rng);
            out_ready = random_ready ? rng[2] : 1'b1;
            @(negedge clk);
        end
        out_ready = 1'b0;
    endtask

    task automatic reset_test();
        test_errors = 0;
        if (mem_req.req !== 1'b0 || out_pkt.valid !== 1'b0) begin
            $display("mismatch reset_start req/valid expected 0/0 actual %b/%b",
                     mem_req.req, out_pkt.valid);
            test_errors++;
        end
        @(negedge clk);
        if (mem_req.req !== 1'b1 || mem_req.addr !== 32'h1fc0_0000) begin
            $display("mismatch reset_start req/addr expected 1/1fc00000 actual %b/%h",
                     mem_req.req, mem_req.addr);
            test_errors++;
        end
        deliver(4, 1'b0);
        build_expected(fetch_pkg::reset_pc, 4);
        compare_stream("reset_start", 4);
        finish_test("reset_start");
    endtask

    task automatic stream_test(input string name, input logic [31:0] start, input int count,
                               input logic random_ready);
        test_errors = 0;
        pulse_redirect(1'b0, start);
        deliver(count, random_ready);
        build_expected(start, count);
        compare_stream(name, count);
        finish_test(name);
    endtask

    // redirect lands right after a request was accepted, so data is in flight
    task automatic redirect_test(input string name, input logic exc, input logic [31:0] start,
                                 input logic [31:0] epc);
        int seen;
        test_errors = 0;
        pulse_redirect(1'b0, start);
        out_ready = 1'b1;
        while (got_pc.size() < 4 || !(mem_req.req && mem_rsp.addr_ok)) begin
            @(negedge clk);
        end
        @(negedge clk);
        seen = got_pc.size();
        build_expected(start, seen);
        compare_stream(name, seen);
        pulse_redirect(exc, epc);
        deliver(12, 1'b0);
        build_expected(exc ? fetch_pkg::exc_vector : epc, 12);
        compare_stream(name, 12);
        finish_test(name);
    endtask

    task automatic load_programs();
        logic [31:0] blk;
        // j, a beq that needs registers, jal, forward b, backward b
        mem_model.prog[word_index(32'hbfc00800)] = jump_word(fetch_pkg::op_j, 32'hbfc00a00);
        mem_model.prog[word_index(32'hbfc00a00)] = {fetch_pkg::op_beq, 5'd1, 5'd0, 16'h0010};
        mem_model.prog[word_index(32'hbfc00a08)] = jump_word(fetch_pkg::op_jal, 32'hbfc00c00);
        mem_model.prog[word_index(32'hbfc00c04)] = b_word(32'hbfc00c04, 32'hbfc00e00);
        mem_model.prog[word_index(32'hbfc00e0c)] = b_word(32'hbfc00e0c, 32'hbfc00d80);
        // long program, eight blocks chained by b and jal, then j back to the start
        for (int k = 0; k < 8; k++) begin
            blk = 32'hbfc02000 + 32'(k) * 32'h100;
            if (k == 7) begin
                mem_model.prog[word_index(blk + 32'h20)] =
                    jump_word(fetch_pkg::op_j, 32'hbfc02000);
            end else if (k % 2 == 1) begin
                mem_model.prog[word_index(blk + 32'h20)] =
                    jump_word(fetch_pkg::op_jal, blk + 32'h100);
            end else begin
                mem_model.prog[word_index(blk + 32'h20)] = b_word(blk + 32'h20, blk + 32'h110);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        out_ready = 1'b0;
        redirect = '0;
        @(negedge clk);
        load_programs();
        repeat (9) @(negedge clk);
        reset = 1'b0;
        reset_test();
        stream_test("straight_line", 32'hbfc00100, 40, 1'b0);
        stream_test("jumps", 32'hbfc00800, 30, 1'b0);
        stream_test("jumps_stalled", 32'hbfc00800, 30, 1'b1);
        redirect_test("exception", 1'b1, 32'hbfc01000, 32'hbfc01c00);
        redirect_test("eret", 1'b0, 32'hbfc01400, 32'hbfc01800);
        stream_test("long_backpressure", 32'hbfc02000, 150, 1'b1);
        $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
